//--- logic/video_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pixel and color types for the compositor, plus small default raster sizes
// that the top level hands down to the timing generator.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package video_pkg;

    typedef logic [3:0] nibble_t;           // one 4-bit color or alpha field

    // playfield A uses the top nibble for control, playfield B for alpha
    typedef struct packed {
        nibble_t a;                         // alpha / control bits
        nibble_t r;                         // red
        nibble_t g;                         // green
        nibble_t b;                         // blue
    } argb_t;

    typedef struct packed {
        nibble_t r;                         // red
        nibble_t g;                         // green
        nibble_t b;                         // blue
    } rgb_t;

    typedef logic [9:0] coord_t;            // pixel column or line number

    localparam int A_OPAQUE_BIT = 15;       // A weight forced to full
    localparam int A_HIDE_B_BIT = 14;       // B weight forced to zero

    // tiny raster so a whole frame simulates quickly
    localparam int H_ACTIVE = 16;           // visible pixels per line
    localparam int H_FRONT  = 2;            // front porch
    localparam int H_SYNC   = 4;            // hsync width
    localparam int H_BACK   = 2;            // back porch
    localparam int V_ACTIVE = 8;            // visible lines per frame
    localparam int V_FRONT  = 1;            // front porch lines
    localparam int V_SYNC   = 2;            // vsync width in lines
    localparam int V_BACK   = 1;            // back porch lines

endpackage

//--- logic/host_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types for the host side: palette index, playfield select, port FSM state.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package host_pkg;

    typedef logic [7:0] pal_addr_t;         // 256 palette entries

    typedef enum logic {
        PF_A = 1'b0,                        // column-indexed playfield
        PF_B = 1'b1                         // row-indexed playfield
    } pf_sel_e;

    typedef enum logic [1:0] {
        HS_IDLE = 2'd0,                     // waiting for req
        HS_ACK  = 2'd1,                     // write done, ack just raised
        HS_WAIT = 2'd2                      // ack held until req drops
    } hs_state_e;

endpackage

//--- logic/pixel_bus_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video stream between pipeline stages: syncs, enable and one pixel whose
// type is chosen per instance (ARGB from palettes, RGB out of the blend).
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface pixel_bus_if #(
    parameter type PIXEL_T = video_pkg::argb_t
);

    logic   vsync;                          // active high
    logic   hsync;                          // active high
    logic   de;                             // display enable
    PIXEL_T pixel;                          // color for this cycle

    modport src (
        output vsync, hsync, de, pixel
    );

    modport dst (
        input  vsync, hsync, de, pixel
    );

endinterface

//--- logic/video_timing.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free-running raster generator. Syncs, enable and x/y leave on registers.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module video_timing #(
    parameter int H_ACTIVE = video_pkg::H_ACTIVE,
    parameter int H_FRONT  = video_pkg::H_FRONT,
    parameter int H_SYNC   = video_pkg::H_SYNC,
    parameter int H_BACK   = video_pkg::H_BACK,
    parameter int V_ACTIVE = video_pkg::V_ACTIVE,
    parameter int V_FRONT  = video_pkg::V_FRONT,
    parameter int V_SYNC   = video_pkg::V_SYNC,
    parameter int V_BACK   = video_pkg::V_BACK
) (
    input  logic              clk,
    input  logic              rst_n_i,
    output logic              hsync_o,
    output logic              vsync_o,
    output logic              de_o,
    output video_pkg::coord_t x_o,
    output video_pkg::coord_t y_o
);

    localparam int H_TOTAL   = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL   = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_SYNC_LO = H_ACTIVE + H_FRONT;      // first hsync pixel
    localparam int V_SYNC_LO = V_ACTIVE + V_FRONT;      // first vsync line

    video_pkg::coord_t h_cnt;               // pixel within line
    video_pkg::coord_t v_cnt;               // line within frame
    logic              line_end;
    logic              frame_end;
    logic              hsync_nxt;
    logic              vsync_nxt;
    logic              de_nxt;

    assign line_end  = (h_cnt == video_pkg::coord_t'(H_TOTAL - 1));
    assign frame_end = (v_cnt == video_pkg::coord_t'(V_TOTAL - 1));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (line_end) begin
            h_cnt <= '0;                    // wrap at line total
            v_cnt <= frame_end ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // decode from counter ranges
    always_comb begin
        hsync_nxt = (h_cnt >= video_pkg::coord_t'(H_SYNC_LO)) &&
                    (h_cnt <  video_pkg::coord_t'(H_SYNC_LO + H_SYNC));
        vsync_nxt = (v_cnt >= video_pkg::coord_t'(V_SYNC_LO)) &&
                    (v_cnt <  video_pkg::coord_t'(V_SYNC_LO + V_SYNC));
        de_nxt    = (h_cnt < video_pkg::coord_t'(H_ACTIVE)) &&
                    (v_cnt < video_pkg::coord_t'(V_ACTIVE));
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            de_o    <= 1'b0;
            x_o     <= '0;
            y_o     <= '0;
        end else begin
            hsync_o <= hsync_nxt;
            vsync_o <= vsync_nxt;
            de_o    <= de_nxt;
            x_o     <= h_cnt;               // same cycle as de
            y_o     <= v_cnt;
        end
    end

endmodule

//--- logic/host_port.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four-phase req/ack slave. Each transfer becomes one palette write pulse.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module host_port (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                req_i,
    input  host_pkg::pf_sel_e   sel_i,
    input  host_pkg::pal_addr_t addr_i,
    input  video_pkg::argb_t    data_i,
    output logic                ack_o,
    output logic                a_wr_en_o,
    output logic                b_wr_en_o,
    output host_pkg::pal_addr_t wr_addr_o,
    output video_pkg::argb_t    wr_data_o
);

    host_pkg::hs_state_e state;
    logic                take;              // accept transfer this cycle

    // write lands on the edge that moves us out of idle, i.e. as ack rises
    assign take      = (state == host_pkg::HS_IDLE) && req_i;
    assign a_wr_en_o = take && (sel_i == host_pkg::PF_A);
    assign b_wr_en_o = take && (sel_i == host_pkg::PF_B);
    assign wr_addr_o = addr_i;              // held stable by host during req
    assign wr_data_o = data_i;
    assign ack_o     = (state != host_pkg::HS_IDLE);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= host_pkg::HS_IDLE;
        end else begin
            case (state)
                host_pkg::HS_IDLE: begin
                    if (req_i) state <= host_pkg::HS_ACK;
                end
                host_pkg::HS_ACK: begin
                    state <= req_i ? host_pkg::HS_WAIT : host_pkg::HS_IDLE;
                end
                host_pkg::HS_WAIT: begin
                    if (!req_i) state <= host_pkg::HS_IDLE;   // ack drops next
                end
                default: state <= host_pkg::HS_IDLE;
            endcase
        end
    end

endmodule

//--- logic/playfield_palette.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 256-entry ARGB palette. Looks up by column or row, one cycle of latency,
// with the raster syncs delayed alongside the pixel.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module playfield_palette #(
    parameter bit INDEX_BY_ROW = 1'b0       // 0 = index by x, 1 = by y
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                wr_en_i,
    input  host_pkg::pal_addr_t wr_addr_i,
    input  video_pkg::argb_t    wr_data_i,
    input  video_pkg::coord_t   x_i,
    input  video_pkg::coord_t   y_i,
    input  logic                hsync_i,
    input  logic                vsync_i,
    input  logic                de_i,
    pixel_bus_if.src            pix
);

    video_pkg::argb_t    pal_mem [256];     // block RAM
    host_pkg::pal_addr_t rd_idx;            // lookup index, low 8 bits

    assign rd_idx = INDEX_BY_ROW ? y_i[7:0] : x_i[7:0];

    // host write port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            pal_mem[wr_addr_i] <= wr_data_i;
        end
    end

    // registered read, one cycle behind the coordinates
    always_ff @(posedge clk) begin
        pix.pixel <= pal_mem[rd_idx];
    end

    // syncs follow the RAM latency so the bus stays aligned
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pix.hsync <= 1'b0;
            pix.vsync <= 1'b0;
            pix.de    <= 1'b0;
        end else begin
            pix.hsync <= hsync_i;
            pix.vsync <= vsync_i;
            pix.de    <= de_i;
        end
    end

endmodule

//--- logic/video_blend.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Blends playfield A over B with B's alpha and A's control bits. Three
// register stages: expand and weigh, multiply, sum and saturate to RGB.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module video_blend (
    input  logic     clk,
    input  logic     rst_n_i,
    pixel_bus_if.dst pf_a,
    pixel_bus_if.dst pf_b,
    pixel_bus_if.src out
);

    logic [7:0]      col_a  [3];            // A r/g/b widened to 8 bits
    logic [7:0]      col_b  [3];            // B r/g/b widened to 8 bits
    logic [7:0]      wgt_a;                 // A weight
    logic [7:0]      wgt_b;                 // B weight
    logic [15:0]     prod_a [3];            // A channel * A weight
    logic [15:0]     prod_b [3];            // B channel * B weight
    logic [7:0]      sum    [3];            // bit 7 is overflow
    logic [3:0]      sat    [3];            // saturated nibble
    video_pkg::rgb_t mix;                   // blended color before blanking
    logic [2:0]      sync_p1;               // {vsync, hsync, de} after stage 1
    logic [2:0]      sync_p2;               // after stage 2
    logic            de_in;

    // nibble repeated, so F maps to FF
    function automatic logic [7:0] expand(input video_pkg::nibble_t n);
        return {n, n};
    endfunction

    assign de_in = pf_a.de & pf_b.de;       // both palettes run in lockstep

    // stage 1: widen channels, pick weights
    always_ff @(posedge clk) begin
        col_a[0] <= expand(pf_a.pixel.r);
        col_a[1] <= expand(pf_a.pixel.g);
        col_a[2] <= expand(pf_a.pixel.b);
        col_b[0] <= expand(pf_b.pixel.r);
        col_b[1] <= expand(pf_b.pixel.g);
        col_b[2] <= expand(pf_b.pixel.b);

        if (pf_a.pixel[video_pkg::A_OPAQUE_BIT]) begin
            wgt_a <= 8'hFF;                 // A fully opaque
        end else begin
            wgt_a <= expand(~pf_b.pixel.a); // inverse of B alpha
        end

        if (pf_a.pixel[video_pkg::A_HIDE_B_BIT]) begin
            wgt_b <= 8'h00;                 // B hidden
        end else begin
            wgt_b <= expand(pf_b.pixel.a);
        end
    end

    // stage 2: six 8x8 products
    always_ff @(posedge clk) begin
        for (int c = 0; c < 3; c++) begin
            prod_a[c] <= col_a[c] * wgt_a;
            prod_b[c] <= col_b[c] * wgt_b;
        end
    end

    // stage 3 comb part: top 7 bits of each product, add, clamp
    always_comb begin
        for (int c = 0; c < 3; c++) begin
            sum[c] = 8'(prod_a[c][15:9]) + 8'(prod_b[c][15:9]);
            sat[c] = sum[c][7] ? 4'hF : sum[c][6:3];
        end
        mix = '{r: sat[0], g: sat[1], b: sat[2]};
    end

    // sync delay line and the output register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_p1   <= '0;
            sync_p2   <= '0;
            out.vsync <= 1'b0;
            out.hsync <= 1'b0;
            out.de    <= 1'b0;
            out.pixel <= '0;
        end else begin
            sync_p1   <= {pf_a.vsync, pf_a.hsync, de_in};
            sync_p2   <= sync_p1;
            out.vsync <= sync_p2[2];
            out.hsync <= sync_p2[1];
            out.de    <= sync_p2[0];
            if (sync_p2[0]) begin
                out.pixel <= mix;
            end else begin
                out.pixel <= '0;            // black outside the active area
            end
        end
    end

endmodule

//--- logic/video_blend_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Compositor top: raster timing, two palettes, blend and the host port.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module video_blend_top #(
    parameter int H_ACTIVE = video_pkg::H_ACTIVE,
    parameter int H_FRONT  = video_pkg::H_FRONT,
    parameter int H_SYNC   = video_pkg::H_SYNC,
    parameter int H_BACK   = video_pkg::H_BACK,
    parameter int V_ACTIVE = video_pkg::V_ACTIVE,
    parameter int V_FRONT  = video_pkg::V_FRONT,
    parameter int V_SYNC   = video_pkg::V_SYNC,
    parameter int V_BACK   = video_pkg::V_BACK
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                host_req_i,
    input  host_pkg::pf_sel_e   host_sel_i,
    input  host_pkg::pal_addr_t host_addr_i,
    input  video_pkg::argb_t    host_data_i,
    output logic                host_ack_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                de_o,
    output video_pkg::rgb_t     rgb_o
);

    logic                tm_hsync;          // raster timing, registered
    logic                tm_vsync;
    logic                tm_de;
    video_pkg::coord_t   tm_x;
    video_pkg::coord_t   tm_y;
    logic                a_wr_en;           // palette write steering
    logic                b_wr_en;
    host_pkg::pal_addr_t wr_addr;
    video_pkg::argb_t    wr_data;

    pixel_bus_if #(.PIXEL_T(video_pkg::argb_t)) pf_a_bus ();
    pixel_bus_if #(.PIXEL_T(video_pkg::argb_t)) pf_b_bus ();
    pixel_bus_if #(.PIXEL_T(video_pkg::rgb_t))  blend_bus ();

    video_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_video_timing (
        .clk(clk), .rst_n_i(rst_n_i),
        .hsync_o(tm_hsync), .vsync_o(tm_vsync), .de_o(tm_de),
        .x_o(tm_x), .y_o(tm_y)
    );

    host_port u_host_port (
        .clk(clk), .rst_n_i(rst_n_i),
        .req_i(host_req_i), .sel_i(host_sel_i), .addr_i(host_addr_i),
        .data_i(host_data_i), .ack_o(host_ack_o),
        .a_wr_en_o(a_wr_en), .b_wr_en_o(b_wr_en),
        .wr_addr_o(wr_addr), .wr_data_o(wr_data)
    );

    playfield_palette #(.INDEX_BY_ROW(1'b0)) u_palette_a (     // by column
        .clk(clk), .rst_n_i(rst_n_i),
        .wr_en_i(a_wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
        .x_i(tm_x), .y_i(tm_y),
        .hsync_i(tm_hsync), .vsync_i(tm_vsync), .de_i(tm_de),
        .pix(pf_a_bus.src)
    );

    playfield_palette #(.INDEX_BY_ROW(1'b1)) u_palette_b (     // by row
        .clk(clk), .rst_n_i(rst_n_i),
        .wr_en_i(b_wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
        .x_i(tm_x), .y_i(tm_y),
        .hsync_i(tm_hsync), .vsync_i(tm_vsync), .de_i(tm_de),
        .pix(pf_b_bus.src)
    );

    video_blend u_video_blend (
        .clk(clk), .rst_n_i(rst_n_i),
        .pf_a(pf_a_bus.dst), .pf_b(pf_b_bus.dst), .out(blend_bus.src)
    );

    assign hsync_o = blend_bus.hsync;
    assign vsync_o = blend_bus.vsync;
    assign de_o    = blend_bus.de;
    assign rgb_o   = blend_bus.pixel;

endmodule

//--- testbench/video_blend_assert.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Handshake and blanking properties, bound onto the compositor top level.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module video_blend_assert (
    input logic            clk,
    input logic            rst_n_i,
    input logic            req_i,          // host_req_i of the top
    input logic            ack_i,          // host_ack_o of the top
    input logic            de_i,           // de_o of the top
    input video_pkg::rgb_t rgb_i           // rgb_o of the top
);

    // ack rises only while the host holds req
    ack_rise_with_req: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $rose(ack_i) |-> req_i
    ) else $error("host_ack_o rose while host_req_i was low");

    // ack falls only once req has dropped
    ack_fall_after_req: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $fell(ack_i) |-> !$past(req_i)
    ) else $error("host_ack_o fell before host_req_i dropped");

    // ack stays up as long as req does
    ack_hold_with_req: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (req_i && ack_i) |=> ack_i
    ) else $error("host_ack_o dropped while host_req_i was still high");

    // black outside the active area
    blank_when_no_de: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !de_i |-> (rgb_i == '0)
    ) else $error("rgb_o not black while de_o low");

endmodule

//--- testbench/video_blend_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests for the compositor: reset, host handshake, control bits,
// alpha blend against a reference model, blanking and raster counts.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module video_blend_tb;

    localparam int H_ACT     = video_pkg::H_ACTIVE;
    localparam int V_ACT     = video_pkg::V_ACTIVE;
    localparam int H_TOTAL   = H_ACT + video_pkg::H_FRONT + video_pkg::H_SYNC
                             + video_pkg::H_BACK;
    localparam int V_TOTAL   = V_ACT + video_pkg::V_FRONT + video_pkg::V_SYNC
                             + video_pkg::V_BACK;
    localparam int H_SYNC_LO = H_ACT + video_pkg::H_FRONT;  // first hsync pixel of a line
    localparam int H_SYNC_W  = video_pkg::H_SYNC;
    localparam int V_SYNC_W  = video_pkg::V_SYNC;
    localparam int FRAME_CYC = H_TOTAL * V_TOTAL;   // clocks per frame
    localparam int ACK_LIMIT = 20;                  // clocks allowed per ack edge

    logic                clk;
    logic                rst_n;
    logic                host_req;
    host_pkg::pf_sel_e   host_sel;
    host_pkg::pal_addr_t host_addr;
    video_pkg::argb_t    host_data;
    logic                host_ack;
    logic                hsync;
    logic                vsync;
    logic                de;
    video_pkg::rgb_t     rgb;

    video_pkg::argb_t    shadow_a [256];            // what palette A should hold
    video_pkg::argb_t    shadow_b [256];            // what palette B should hold
    int                  errors;
    int                  checks;
    int                  tests_run;
    int                  tests_bad;

    video_blend_top u_video_blend_top (
        .clk(clk), .rst_n_i(rst_n),
        .host_req_i(host_req), .host_sel_i(host_sel), .host_addr_i(host_addr),
        .host_data_i(host_data), .host_ack_o(host_ack),
        .hsync_o(hsync), .vsync_o(vsync), .de_o(de), .rgb_o(rgb)
    );

    bind video_blend_top video_blend_assert u_video_blend_assert (
        .clk(clk), .rst_n_i(rst_n_i), .req_i(host_req_i), .ack_i(host_ack_o),
        .de_i(de_o), .rgb_i(rgb_o)
    );

    always #20 clk = ~clk;                          // 40 ns period

    // expected output color for A over B
    function automatic video_pkg::rgb_t blend_model(input video_pkg::argb_t pa,
                                                    input video_pkg::argb_t pb);
        logic [3:0]  chan_a [3];
        logic [3:0]  chan_b [3];
        logic [3:0]  res    [3];
        logic [7:0]  wa;
        logic [7:0]  wb;
        logic [15:0] ma;
        logic [15:0] mb;
        logic [7:0]  total;
        chan_a[0] = pa.r;
        chan_a[1] = pa.g;
        chan_a[2] = pa.b;
        chan_b[0] = pb.r;
        chan_b[1] = pb.g;
        chan_b[2] = pb.b;
        wa = pa[15] ? 8'hFF : {~pb.a, ~pb.a};       // opaque A takes full weight
        wb = pa[14] ? 8'h00 : {pb.a, pb.a};         // hide-B zeroes B
        for (int c = 0; c < 3; c++) begin
            ma    = 16'({chan_a[c], chan_a[c]}) * 16'(wa);
            mb    = 16'({chan_b[c], chan_b[c]}) * 16'(wb);
            total = 8'(ma[15:9]) + 8'(mb[15:9]);
            res[c] = total[7] ? 4'hF : total[6:3];  // clamp on overflow
        end
        return '{r: res[0], g: res[1], b: res[2]};
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic wait_ack(input logic level, output bit ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < ACK_LIMIT) begin
            @(negedge clk);
            ok = (host_ack == level);
            n++;
        end
        if (!ok) begin
            errors++;
            $display("timeout at %0t: host_ack_o did not go to %0d within %0d clocks",
                     $time, level, ACK_LIMIT);
        end
    endtask

    // full four-phase transfer, req held hold extra clocks after ack
    task automatic host_write(input host_pkg::pf_sel_e sel, input host_pkg::pal_addr_t addr,
                              input video_pkg::argb_t data, input int hold);
        bit ok;
        @(posedge clk);
        #2;
        check_eq("host_ack_o before req", 32'(host_ack), 32'd0);
        host_sel  = sel;
        host_addr = addr;
        host_data = data;
        host_req  = 1'b1;
        wait_ack(1'b1, ok);
        if (ok) begin
            for (int i = 0; i < hold; i++) begin
                @(negedge clk);
                check_eq("host_ack_o while req held", 32'(host_ack), 32'd1);
            end
        end
        @(posedge clk);
        #2;
        host_req = 1'b0;
        wait_ack(1'b0, ok);
        if (sel == host_pkg::PF_A) begin
            shadow_a[addr] = data;
        end else begin
            shadow_b[addr] = data;
        end
    endtask

    task automatic wait_vsync_fall(output bit ok);
        logic prev;
        int   n;
        ok   = 1'b0;
        n    = 0;
        prev = vsync;
        while (!ok && n < 2 * FRAME_CYC) begin
            @(negedge clk);
            ok   = prev && !vsync;
            prev = vsync;
            n++;
        end
        if (!ok) begin
            errors++;
            $display("timeout at %0t: vsync_o never fell within two frames", $time);
        end
    endtask

    // one frame from vsync fall to vsync fall, position from output ports only
    task automatic check_frame();
        bit   ok;
        bit   done;
        logic prev_de;
        logic prev_vs;
        int   px;
        int   row;
        int   n;
        int   hpos;
        wait_vsync_fall(ok);
        if (!ok) return;
        prev_de = 1'b0;
        prev_vs = 1'b0;
        px      = 0;
        row     = -1;                               // first de rise makes it 0
        n       = 0;
        done    = 1'b0;
        while (!done && n < 2 * FRAME_CYC) begin
            hpos = n % H_TOTAL;                     // vsync falls at a line start
            check_eq("hsync_o", 32'(hsync),
                     32'(hpos >= H_SYNC_LO && hpos < H_SYNC_LO + H_SYNC_W));
            check_eq("vsync_o", 32'(vsync), 32'(n / H_TOTAL >= V_TOTAL - V_SYNC_W));
            if (de && !prev_de) begin
                row++;
                px = 0;
            end
            if (!de && prev_de) begin
                check_eq($sformatf("de_o pixels on line %0d", row), 32'(px), 32'(H_ACT));
            end
            if (de) begin
                if (row < V_ACT && px < H_ACT) begin
                    check_eq($sformatf("rgb_o(%0d,%0d)", px, row), 32'(rgb),
                             32'(blend_model(shadow_a[px], shadow_b[row])));
                end
                px++;
            end else begin
                check_eq("rgb_o while blanked", 32'(rgb), 32'd0);
            end
            prev_de = de;
            prev_vs = vsync;
            @(negedge clk);
            n++;
            done = prev_vs && !vsync;               // next frame starts
        end
        if (!done) begin
            errors++;
            $display("timeout at %0t: frame did not end within two frame times", $time);
        end else begin
            check_eq("clocks per frame", 32'(n), 32'(FRAME_CYC));
        end
        check_eq("active lines per frame", 32'(row + 1), 32'(V_ACT));
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors > err_before) begin
            tests_bad++;
        end
        $display("test %s: %0d error(s)", name, errors - err_before);
    endtask

    task automatic reset_values();
        int e0;
        e0 = errors;
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);                             // still inside reset
        check_eq("host_ack_o in reset", 32'(host_ack), 32'd0);
        check_eq("rgb_o in reset", 32'(rgb), 32'd0);
        @(posedge clk);
        #2;
        rst_n = 1'b1;                               // released after 4 clocks
        @(negedge clk);
        check_eq("host_ack_o", 32'(host_ack), 32'd0);
        check_eq("hsync_o", 32'(hsync), 32'd0);
        check_eq("vsync_o", 32'(vsync), 32'd0);
        check_eq("de_o", 32'(de), 32'd0);
        check_eq("rgb_o", 32'(rgb), 32'd0);
        report_test("reset", e0);
    endtask

    task automatic handshake_order();
        int e0;
        e0 = errors;
        host_write(host_pkg::PF_B, 8'hF0, 16'h1234, 3);     // long req hold
        host_write(host_pkg::PF_A, 8'hF1, 16'h4321, 0);     // drop right away
        host_write(host_pkg::PF_A, 8'hF2, 16'hABCD, 1);
        report_test("handshake", e0);
    endtask

    task automatic control_bits();
        int e0;
        e0 = errors;
        for (int i = 0; i < V_ACT; i++) begin
            host_write(host_pkg::PF_B, 8'(i), video_pkg::argb_t'(16'($urandom)), 0);
        end
        for (int i = 0; i < H_ACT; i++) begin               // opaque and hide-B
            host_write(host_pkg::PF_A, 8'(i),
                       video_pkg::argb_t'({4'b1100, 12'($urandom)}), 0);
        end
        check_frame();
        for (int i = 0; i < H_ACT; i++) begin               // hide-B only
            host_write(host_pkg::PF_A, 8'(i),
                       video_pkg::argb_t'({4'b0100, shadow_a[i][11:0]}), 0);
        end
        check_frame();
        report_test("control bits", e0);
    endtask

    task automatic random_blend();
        int e0;
        e0 = errors;
        for (int i = 0; i < H_ACT; i++) begin
            host_write(host_pkg::PF_A, 8'(i), video_pkg::argb_t'(16'($urandom)), 0);
        end
        for (int i = 0; i < V_ACT; i++) begin
            host_write(host_pkg::PF_B, 8'(i), video_pkg::argb_t'(16'($urandom)), 0);
        end
        host_write(host_pkg::PF_A, 8'h00, 16'h8FFF, 0);    // pixel (0,0) saturates
        host_write(host_pkg::PF_B, 8'h00, 16'hFFFF, 0);
        check_frame();
        report_test("alpha blend", e0);
    endtask

    task automatic blanking_and_raster();
        int e0;
        e0 = errors;
        check_frame();                              // two more frames
        check_frame();
        report_test("blanking and raster", e0);
    endtask

    initial begin
        void'($urandom(32'h6d6b_aea7));
        clk       = 1'b0;
        rst_n     = 1'b0;
        host_req  = 1'b0;
        host_sel  = host_pkg::PF_A;
        host_addr = '0;
        host_data = '0;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        tests_bad = 0;

        reset_values();
        handshake_order();
        control_bits();
        random_blend();
        blanking_and_raster();

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- list.f
logic/video_pkg.sv
logic/host_pkg.sv
logic/pixel_bus_if.sv
logic/video_timing.sv
logic/host_port.sv
logic/playfield_palette.sv
logic/video_blend.sv
logic/video_blend_top.sv
testbench/video_blend_assert.sv
testbench/video_blend_tb.sv

//--- Makefile
# Verilator build and run for the video compositor testbench

TOP := video_blend_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' sim.log || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir sim.log
